//--- dv/me_assertions.sv
`timescale 1ns/1ps

module me_assertions
#(
    parameter int MACRO_DIM = 16
)
(
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic valid
);

    // edges from the accepted start to the sampled valid
    localparam int VALID_DELAY = MACRO_DIM + 6;

    int error_count = 0;

    property valid_single;
        @(posedge clk) disable iff (!rst_n)
        valid |=> !valid;
    endproperty

    property busy_ends_with_valid;
        @(posedge clk) disable iff (!rst_n)
        valid |=> !busy;
    endproperty

    property valid_from_start;
        @(posedge clk) disable iff (!rst_n)
        valid |-> $past(start && !busy, VALID_DELAY);
    endproperty

    property start_sets_busy;
        @(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy;
    endproperty

    // async reset, so outputs are already low at the first edge
    property quiet_in_reset;
        @(posedge clk)
        !rst_n |-> (!busy && !valid);
    endproperty

    assert property (valid_single)
    else
    begin
        $error("valid stayed high for more than one cycle");
        error_count++;
    end

    assert property (busy_ends_with_valid)
    else
    begin
        $error("busy still high after valid");
        error_count++;
    end

    assert property (valid_from_start)
    else
    begin
        $error("valid without an accepted start at the expected distance");
        error_count++;
    end

    assert property (start_sets_busy)
    else
    begin
        $error("busy did not rise after an accepted start");
        error_count++;
    end

    assert property (quiet_in_reset)
    else
    begin
        $error("busy or valid high during reset");
        error_count++;
    end

endmodule

bind me_top me_assertions
#(
    .MACRO_DIM (MACRO_DIM)
)
u_assertions
(
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .valid (valid)
);

//--- dv/me_tb.sv
`timescale 1ns/1ps

module me_tb;

    import me_pkg::*;

    localparam int MACRO_DIM  = 16;
    localparam int SEARCH_DIM = 48;
    localparam int MAX_OFFSET = SEARCH_DIM - MACRO_DIM;
    localparam int TIMEOUT    = 4 * (MACRO_DIM + 6);

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic [5:0]              offset;
    pixel_t [MACRO_DIM-1:0]  cur_row;
    pixel_t [SEARCH_DIM-1:0] srch_row;
    logic                    busy;
    logic                    valid;
    sad_t                    sad;

    // one block of stimulus in row order
    pixel_t cur_blk  [MACRO_DIM][MACRO_DIM];
    pixel_t srch_blk [MACRO_DIM][SEARCH_DIM];

    int test_num;
    int test_errors;
    int passed;
    int failed;
    bit aborted;

    me_top
    #(
        .MACRO_DIM  (MACRO_DIM),
        .SEARCH_DIM (SEARCH_DIM)
    )
    UUT
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .offset   (offset),
        .cur_row  (cur_row),
        .srch_row (srch_row),
        .busy     (busy),
        .valid    (valid),
        .sad      (sad)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sum of |cur - srch| over the clamped window
    function automatic int ref_sad(input int off);
        int base;
        int total;
        int d;
        base  = (off > MAX_OFFSET) ? MAX_OFFSET : off;
        total = 0;
        for (int i = 0; i < MACRO_DIM; i++)
        begin
            for (int j = 0; j < MACRO_DIM; j++)
            begin
                d = int'(cur_blk[i][j]) - int'(srch_blk[i][base + j]);
                if (d < 0)
                begin
                    d = -d;
                end
                total += d;
            end
        end
        return total;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < MACRO_DIM; i++)
        begin
            for (int j = 0; j < MACRO_DIM; j++)
            begin
                cur_blk[i][j] = pixel_t'($urandom_range(0, 255));
            end
            for (int k = 0; k < SEARCH_DIM; k++)
            begin
                srch_blk[i][k] = pixel_t'($urandom_range(0, 255));
            end
        end
    endtask

    // window at off is a copy of the current block
    task automatic fill_match(input int off);
        fill_random();
        for (int i = 0; i < MACRO_DIM; i++)
        begin
            for (int j = 0; j < MACRO_DIM; j++)
            begin
                srch_blk[i][off + j] = cur_blk[i][j];
            end
        end
    endtask

    task automatic fill_extremes();
        for (int i = 0; i < MACRO_DIM; i++)
        begin
            for (int j = 0; j < MACRO_DIM; j++)
            begin
                cur_blk[i][j] = 8'h00;
            end
            for (int k = 0; k < SEARCH_DIM; k++)
            begin
                srch_blk[i][k] = 8'hff;
            end
        end
    endtask

    task automatic drive_row(input int i);
        for (int j = 0; j < MACRO_DIM; j++)
        begin
            cur_row[j] = cur_blk[i][j];
        end
        for (int k = 0; k < SEARCH_DIM; k++)
        begin
            srch_row[k] = srch_blk[i][k];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("Fail %s exp=%h got=%h", name, exp, got);
            test_errors++;
        end
    endtask

    task automatic wait_busy(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (busy === level);
        if (!ok)
        begin
            $display("timeout: busy never reached %0b", level);
        end
    endtask

    task automatic wait_valid(output bit ok);
        int cycles;
        cycles = 0;
        while (valid !== 1'b1 && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (valid === 1'b1);
        if (!ok)
        begin
            $display("timeout: no valid after the row stream");
        end
    endtask

    // start is raised during row stray_row unless it is -1
    task automatic run_block(input int off, input int stray_row, output int got);
        bit ok;
        got = -1;
        if (!aborted)
        begin
            wait_busy(1'b0, ok);
            if (ok)
            begin
                offset = 6'(off);
                start  = 1'b1;
                @(negedge clk);
                wait_busy(1'b1, ok);
            end
            if (ok)
            begin
                start = 1'b0;
                drive_row(0);
                for (int i = 1; i < MACRO_DIM; i++)
                begin
                    @(negedge clk);
                    drive_row(i);
                    start = (i == stray_row);
                end
                @(negedge clk);
                start = 1'b0;
                wait_valid(ok);
            end
            if (ok)
            begin
                got = int'(sad);
            end
            else
            begin
                aborted = 1'b1;
            end
        end
    endtask

    task automatic score_block(input int off);
        int got;
        run_block(off, -1, got);
        if (!aborted)
        begin
            check_value("sad", ref_sad(off), got);
        end
    endtask

    task automatic begin_test();
        test_num++;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        if (aborted)
        begin
            test_errors++;
        end
        if (test_errors == 0)
        begin
            passed++;
            $display("test %0d %s: ok", test_num, name);
        end
        else
        begin
            failed++;
            $display("test %0d %s: %0d errors", test_num, name, test_errors);
        end
    endtask

    initial
    begin
        int off;
        int got;
        int exp_a;
        int extra;
        int assert_errors;

        void'($urandom(48087));
        rst_n    = 1'b0;
        start    = 1'b0;
        offset   = '0;
        cur_row  = '0;
        srch_row = '0;
        passed   = 0;
        failed   = 0;
        test_num = 0;
        aborted  = 1'b0;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        check_value("busy", 0, busy);
        check_value("valid", 0, valid);
        check_value("sad", 0, sad);
        end_test("reset values");

        begin_test();
        fill_random();
        score_block(0);
        end_test("offset 0");

        begin_test();
        fill_random();
        score_block($urandom_range(1, MAX_OFFSET - 1));
        end_test("random offset");

        begin_test();
        fill_random();
        score_block(MAX_OFFSET);
        end_test("max offset");

        // 40 should land on the same window as 32
        begin_test();
        fill_random();
        score_block(40);
        end_test("clamped offset");

        begin_test();
        off = $urandom_range(0, MAX_OFFSET);
        fill_match(off);
        run_block(off, -1, got);
        if (!aborted)
        begin
            check_value("sad", 0, got);
        end
        end_test("identical rows");

        begin_test();
        fill_extremes();
        run_block(0, -1, got);
        if (!aborted)
        begin
            check_value("sad", MACRO_DIM * MACRO_DIM * 255, got);
        end
        end_test("0 against 255");

        begin_test();
        fill_random();
        off = $urandom_range(0, MAX_OFFSET);
        run_block(off, 5, got);
        if (!aborted)
        begin
            check_value("sad", ref_sad(off), got);
            extra = 0;
            repeat (2 * (MACRO_DIM + 6))
            begin
                @(negedge clk);
                if (valid === 1'b1)
                begin
                    extra++;
                end
            end
            check_value("extra valid", 0, extra);
        end
        end_test("start while busy");

        begin_test();
        fill_random();
        off = $urandom_range(0, MAX_OFFSET);
        run_block(off, -1, got);
        if (!aborted)
        begin
            exp_a = ref_sad(off);
            check_value("sad", exp_a, got);
            @(negedge clk);
            check_value("sad hold", exp_a, sad);
        end
        fill_random();
        score_block($urandom_range(0, MAX_OFFSET));
        end_test("back to back");

        assert_errors = UUT.u_assertions.error_count;
        $display("tests=%0d passed=%0d failed=%0d assertion_errors=%0d",
                 test_num, passed, failed, assert_errors);
        if (aborted || failed > 0 || assert_errors > 0)
        begin
            $display("RESULT: FAIL");
        end
        else
        begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

//--- source/me_controller.sv
`timescale 1ns/1ps

module me_controller
#(
    parameter int MACRO_DIM = 16
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load,
    output logic row_en,
    output logic busy,
    output logic valid
);

    import me_pkg::*;

    // row stream, then fetch, tree and accumulator drain
    localparam int LAST_COUNT = MACRO_DIM + 4;

    me_state_t          state;
    me_state_t          next_state;
    logic [COUNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                begin
                    next_state = ST_RUN;
                end
            end
            ST_RUN:
            begin
                if (count == COUNT_W'(LAST_COUNT))
                begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE:
            begin
                next_state = ST_IDLE;
            end
            default:
            begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // counts only while running
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (state != ST_RUN)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // start only counts in idle
    assign load   = (state == ST_IDLE) && start;
    assign row_en = (state == ST_RUN) && (count < COUNT_W'(MACRO_DIM));
    assign busy   = (state != ST_IDLE);
    assign valid  = (state == ST_DONE);

endmodule

//--- source/me_pkg.sv
package me_pkg;

    // luma samples
    localparam int PIXEL_W = 8;

    // wide enough for 16x16 differences of 255
    localparam int SAD_W = 16;

    // row counter wide enough for MACRO_DIM+4 with MACRO_DIM up to 16
    localparam int COUNT_W = 5;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // every partial and final sum
    typedef logic [SAD_W-1:0] sad_t;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } me_state_t;

endpackage

//--- source/me_top.sv
`timescale 1ns/1ps

module me_top
#(
    parameter int MACRO_DIM  = 16,
    parameter int SEARCH_DIM = 48
)
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [5:0]                       offset,
    input  me_pkg::pixel_t [MACRO_DIM-1:0]  cur_row,
    input  me_pkg::pixel_t [SEARCH_DIM-1:0] srch_row,
    output logic                             busy,
    output logic                             valid,
    output me_pkg::sad_t                     sad
);

    import me_pkg::*;

    logic                   load;
    logic                   row_en;
    pixel_t [MACRO_DIM-1:0] diff;
    logic                   diff_vld;
    sad_t                   tree_sum;
    logic                   sum_vld;

    me_controller
    #(
        .MACRO_DIM (MACRO_DIM)
    )
    u_controller
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .load   (load),
        .row_en (row_en),
        .busy   (busy),
        .valid  (valid)
    );

    pixel_fetch_stage
    #(
        .MACRO_DIM  (MACRO_DIM),
        .SEARCH_DIM (SEARCH_DIM)
    )
    u_fetch
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .row_en   (row_en),
        .offset   (offset),
        .cur_row  (cur_row),
        .srch_row (srch_row),
        .diff     (diff),
        .diff_vld (diff_vld)
    );

    sad_adder_tree
    #(
        .MACRO_DIM (MACRO_DIM)
    )
    u_tree
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .diff     (diff),
        .diff_vld (diff_vld),
        .tree_sum (tree_sum),
        .sum_vld  (sum_vld)
    );

    sad_accumulator u_accumulator
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .tree_sum (tree_sum),
        .sum_vld  (sum_vld),
        .sad      (sad)
    );

endmodule

//--- source/pixel_fetch_stage.sv
`timescale 1ns/1ps

module pixel_fetch_stage
#(
    parameter int MACRO_DIM  = 16,
    parameter int SEARCH_DIM = 48
)
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             load,
    input  logic                             row_en,
    input  logic [5:0]                       offset,
    input  me_pkg::pixel_t [MACRO_DIM-1:0]  cur_row,
    input  me_pkg::pixel_t [SEARCH_DIM-1:0] srch_row,
    output me_pkg::pixel_t [MACRO_DIM-1:0]  diff,
    output logic                             diff_vld
);

    import me_pkg::*;

    // rightmost legal window start
    localparam int MAX_OFFSET = SEARCH_DIM - MACRO_DIM;

    logic [5:0]             offset_q;
    pixel_t [MACRO_DIM-1:0] window;
    pixel_t [MACRO_DIM-1:0] abs_diff;

    function automatic pixel_t pixel_abs_diff(input pixel_t a, input pixel_t b);
        pixel_t d;
        if (a > b)
        begin
            d = a - b;
        end
        else
        begin
            d = b - a;
        end
        return d;
    endfunction

    // held for the whole block
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            offset_q <= '0;
        end
        else if (load)
        begin
            if (offset > MAX_OFFSET)
            begin
                offset_q <= 6'(MAX_OFFSET);
            end
            else
            begin
                offset_q <= offset;
            end
        end
    end

    always_comb
    begin
        for (int j = 0; j < MACRO_DIM; j++)
        begin
            window[j]   = srch_row[offset_q + j];
            abs_diff[j] = pixel_abs_diff(cur_row[j], window[j]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (row_en)
        begin
            diff <= abs_diff;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            diff_vld <= 1'b0;
        end
        else
        begin
            diff_vld <= row_en;
        end
    end

endmodule

//--- source/sad_accumulator.sv
`timescale 1ns/1ps

module sad_accumulator
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         load,
    input  me_pkg::sad_t tree_sum,
    input  logic         sum_vld,
    output me_pkg::sad_t sad
);

    // load always lands ahead of the first row sum
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sad <= '0;
        end
        else if (load)
        begin
            sad <= '0;
        end
        else if (sum_vld)
        begin
            sad <= sad + tree_sum;
        end
    end

endmodule

//--- source/sad_adder_tree.sv
`timescale 1ns/1ps

module sad_adder_tree
#(
    parameter int MACRO_DIM = 16
)
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  me_pkg::pixel_t [MACRO_DIM-1:0] diff,
    input  logic                            diff_vld,
    output me_pkg::sad_t                    tree_sum,
    output logic                            sum_vld
);

    import me_pkg::*;

    localparam int LEVELS = $clog2(MACRO_DIM);
    localparam int NODES  = MACRO_DIM - 1;

    // in heap order node n adds entries 2n+1 and 2n+2
    // entries below NODES are registered sums and the rest are the leaves
    sad_t              node [NODES];
    sad_t              operand [2*MACRO_DIM-1];
    logic [LEVELS-1:0] vld_q;

    always_comb
    begin
        for (int n = 0; n < NODES; n++)
        begin
            operand[n] = node[n];
        end
        for (int j = 0; j < MACRO_DIM; j++)
        begin
            operand[NODES + j] = sad_t'(diff[j]);
        end
    end

    // one level per clock, so several rows are in flight
    always_ff @(posedge clk)
    begin
        for (int n = 0; n < NODES; n++)
        begin
            node[n] <= operand[2*n + 1] + operand[2*n + 2];
        end
    end

    // row tag follows the data down the tree
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= (vld_q << 1) | LEVELS'(diff_vld);
        end
    end

    assign tree_sum = node[0];
    assign sum_vld  = vld_q[LEVELS-1];

endmodule

//--- tb.f
source/me_pkg.sv
source/me_controller.sv
source/pixel_fetch_stage.sv
source/sad_adder_tree.sv
source/sad_accumulator.sv
source/me_top.sv
dv/me_assertions.sv
dv/me_tb.sv
